// ==== source/fp_pkg.sv ====
`default_nettype none

package fp_pkg;

  // Prime field parameters
  localparam int FE_BITS = 16;
  localparam logic [FE_BITS-1:0] FE_P = 16'd65521;

  typedef logic [FE_BITS-1:0] fe_t;

  // Element a + b*i of Fp2
  typedef struct packed {
    fe_t re;
    fe_t im;
  } fe2_t;

  typedef struct packed {
    fe_t a;
    fe_t b;
  } fe_pair_t;

  typedef struct packed {
    fe2_t x;
    fe2_t y;
  } fe2_pair_t;

endpackage

`default_nettype wire

// ==== source/stream_pkg.sv ====
`default_nettype none

package stream_pkg;

  // Side information that rides with every request
  typedef struct packed {
    logic [7:0] id;
    logic [1:0] part;
    logic       src;
  } tag_t;

  typedef enum logic {FP_ADD, FP_SUB} fp_op_e;

  typedef struct packed {
    fp_pkg::fe_pair_t opnd;
    tag_t             tag;
  } fp_req_t;

  typedef struct packed {
    fp_pkg::fe_t res;
    tag_t        tag;
  } fp_rsp_t;

  typedef struct packed {
    fp_pkg::fe2_pair_t opnd;
    tag_t              tag;
  } fe2_req_t;

  typedef struct packed {
    fp_pkg::fe2_t res;
    tag_t         tag;
  } fe2_rsp_t;

endpackage

`default_nettype wire

// ==== source/fp_mod_addsub.sv ====
`default_nettype none

module fp_mod_addsub #(
  parameter stream_pkg::fp_op_e OP = stream_pkg::FP_ADD
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_req_valid,
  output logic                o_req_ready,
  input  stream_pkg::fp_req_t i_req,
  output logic                o_rsp_valid,
  input  logic                i_rsp_ready,
  output stream_pkg::fp_rsp_t o_rsp
);

  logic [fp_pkg::FE_BITS:0] raw;
  fp_pkg::fe_t              res;

  // One conditional correction brings the result back into range
  always_comb begin
    if (OP == stream_pkg::FP_ADD) begin
      raw = {1'b0, i_req.opnd.a} + {1'b0, i_req.opnd.b};
      res = (raw >= {1'b0, fp_pkg::FE_P}) ? raw[15:0] - fp_pkg::FE_P : raw[15:0];
    end else begin
      raw = {1'b0, i_req.opnd.a} - {1'b0, i_req.opnd.b};
      res = raw[fp_pkg::FE_BITS] ? raw[15:0] + fp_pkg::FE_P : raw[15:0];
    end
  end

  assign o_req_ready = !o_rsp_valid || i_rsp_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rsp_valid <= 1'b0;
    end else if (o_req_ready) begin
      o_rsp_valid <= i_req_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_req_ready && i_req_valid) begin
      o_rsp.res <= res;
      o_rsp.tag <= i_req.tag;
    end
  end

  a_hold_payload: assert property (@(posedge i_clk) disable iff (i_rst)
    o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp));

endmodule

`default_nettype wire

// ==== source/fp_mod_mul.sv ====
`default_nettype none

module fp_mod_mul (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_req_valid,
  output logic                o_req_ready,
  input  stream_pkg::fp_req_t i_req,
  output logic                o_rsp_valid,
  input  logic                i_rsp_ready,
  output stream_pkg::fp_rsp_t o_rsp
);

  logic              en;
  logic              v1, v2;
  logic [31:0]       prod1;
  logic [19:0]       fold2;
  stream_pkg::tag_t  tag1, tag2;
  logic [16:0]       fold3;

  // Whole pipe moves together whenever the output can accept
  assign en          = !o_rsp_valid || i_rsp_ready;
  assign o_req_ready = en;

  // Second fold of the top four bits, value stays below 2*P
  assign fold3 = {13'd0, fold2[19:16]} * 17'd15 + {1'b0, fold2[15:0]};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      v1          <= 1'b0;
      v2          <= 1'b0;
      o_rsp_valid <= 1'b0;
    end else if (en) begin
      v1          <= i_req_valid;
      v2          <= v1;
      o_rsp_valid <= v2;
    end
  end

  always_ff @(posedge i_clk) begin
    if (en) begin
      prod1 <= i_req.opnd.a * i_req.opnd.b;
      tag1  <= i_req.tag;
      // 2^16 is 15 mod P
      fold2 <= {4'd0, prod1[31:16]} * 20'd15 + {4'd0, prod1[15:0]};
      tag2  <= tag1;
      o_rsp.res <= (fold3 >= {1'b0, fp_pkg::FE_P}) ? fold3[15:0] - fp_pkg::FE_P
                                                   : fold3[15:0];
      o_rsp.tag <= tag2;
    end
  end

  a_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    o_rsp_valid |-> o_rsp.res < fp_pkg::FE_P);

endmodule

`default_nettype wire

// ==== source/fp_resource_share.sv ====
`default_nettype none

module fp_resource_share (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_req_valid [2],
  output logic                o_req_ready [2],
  input  stream_pkg::fp_req_t i_req [2],
  output logic                o_unit_valid,
  input  logic                i_unit_ready,
  output stream_pkg::fp_req_t o_unit_req,
  input  logic                i_unit_rsp_valid,
  output logic                o_unit_rsp_ready,
  input  stream_pkg::fp_rsp_t i_unit_rsp,
  output logic                o_rsp_valid [2],
  input  logic                i_rsp_ready [2],
  output stream_pkg::fp_rsp_t o_rsp [2]
);

  logic ptr;
  logic sel;
  logic dst;

  // Alternate only when both inputs compete
  assign sel = (i_req_valid[0] && i_req_valid[1]) ? ptr : i_req_valid[1];

  always_comb begin
    o_unit_valid   = i_req_valid[0] || i_req_valid[1];
    o_unit_req     = i_req[sel];
    o_unit_req.tag.src = sel;
    o_req_ready[0] = i_unit_ready && !sel;
    o_req_ready[1] = i_unit_ready && sel;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ptr <= 1'b0;
    end else if (o_unit_valid && i_unit_ready) begin
      ptr <= !sel;
    end
  end

  // Results go back to whoever issued them
  assign dst = i_unit_rsp.tag.src;

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      o_rsp_valid[k]     = i_unit_rsp_valid && (dst == k[0]);
      o_rsp[k]           = i_unit_rsp;
      o_rsp[k].tag.src   = 1'b0;
    end
    o_unit_rsp_ready = i_rsp_ready[dst];
  end

  // A transfer comes from the stamped requester and the other one is held off
  a_one_grant: assert property (@(posedge i_clk) disable iff (i_rst)
    o_unit_valid && i_unit_ready |->
      i_req_valid[o_unit_req.tag.src] && !o_req_ready[!o_unit_req.tag.src]);

endmodule

`default_nettype wire

// ==== source/fe2_arithmetic.sv ====
`default_nettype none

module fe2_arithmetic (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_add_valid,
  output logic                 o_add_ready,
  input  stream_pkg::fe2_req_t i_add_req,
  output logic                 o_add_rsp_valid,
  input  logic                 i_add_rsp_ready,
  output stream_pkg::fe2_rsp_t o_add_rsp,
  input  logic                 i_sub_valid,
  output logic                 o_sub_ready,
  input  stream_pkg::fe2_req_t i_sub_req,
  output logic                 o_sub_rsp_valid,
  input  logic                 i_sub_rsp_ready,
  output stream_pkg::fe2_rsp_t o_sub_rsp,
  input  logic                 i_mul_valid,
  output logic                 o_mul_ready,
  input  stream_pkg::fe2_req_t i_mul_req,
  output logic                 o_mul_rsp_valid,
  input  logic                 i_mul_rsp_ready,
  output stream_pkg::fe2_rsp_t o_mul_rsp,
  output logic                 o_add_fp_valid [2],
  input  logic                 i_add_fp_ready [2],
  output stream_pkg::fp_req_t  o_add_fp_req [2],
  input  logic                 i_add_fp_rsp_valid [2],
  output logic                 o_add_fp_rsp_ready [2],
  input  stream_pkg::fp_rsp_t  i_add_fp_rsp [2],
  output logic                 o_sub_fp_valid [2],
  input  logic                 i_sub_fp_ready [2],
  output stream_pkg::fp_req_t  o_sub_fp_req [2],
  input  logic                 i_sub_fp_rsp_valid [2],
  output logic                 o_sub_fp_rsp_ready [2],
  input  stream_pkg::fp_rsp_t  i_sub_fp_rsp [2],
  output logic                 o_mul_fp_valid,
  input  logic                 i_mul_fp_ready,
  output stream_pkg::fp_req_t  o_mul_fp_req,
  input  logic                 i_mul_fp_rsp_valid,
  output logic                 o_mul_fp_rsp_ready,
  input  stream_pkg::fp_rsp_t  i_mul_fp_rsp
);

  // Index 0 is the add path, index 1 the sub path
  logic                 in_valid [2];
  logic                 in_ready [2];
  stream_pkg::fe2_req_t in_req [2];
  logic                 out_valid [2];
  logic                 out_ready [2];
  stream_pkg::fe2_rsp_t out_rsp [2];
  logic                 fp_valid [2];
  logic                 fp_ready [2];
  stream_pkg::fp_req_t  fp_req [2];
  logic                 fp_rsp_valid [2];
  logic                 fp_rsp_ready [2];
  stream_pkg::fp_rsp_t  fp_rsp [2];

  assign in_valid     = '{i_add_valid, i_sub_valid};
  assign in_req       = '{i_add_req, i_sub_req};
  assign out_ready    = '{i_add_rsp_ready, i_sub_rsp_ready};
  assign fp_ready     = '{i_add_fp_ready[0], i_sub_fp_ready[0]};
  assign fp_rsp_valid = '{i_add_fp_rsp_valid[0], i_sub_fp_rsp_valid[0]};
  assign fp_rsp       = '{i_add_fp_rsp[0], i_sub_fp_rsp[0]};
  assign o_add_ready  = in_ready[0];
  assign o_sub_ready  = in_ready[1];
  assign o_add_rsp_valid = out_valid[0];
  assign o_sub_rsp_valid = out_valid[1];
  assign o_add_rsp    = out_rsp[0];
  assign o_sub_rsp    = out_rsp[1];
  assign o_add_fp_valid[0] = fp_valid[0];
  assign o_sub_fp_valid[0] = fp_valid[1];
  assign o_add_fp_req[0]   = fp_req[0];
  assign o_sub_fp_req[0]   = fp_req[1];
  assign o_add_fp_rsp_ready[0] = fp_rsp_ready[0];
  assign o_sub_fp_rsp_ready[0] = fp_rsp_ready[1];

  for (genvar g = 0; g < 2; g++) begin : g_lin
    typedef enum logic {ST_RE, ST_IM} lin_state_e;
    lin_state_e st;
    logic       seen_re;

    // Component-wise work, re first then im
    always_comb begin
      fp_valid[g]            = in_valid[g];
      fp_req[g].opnd.a       = (st == ST_IM) ? in_req[g].opnd.x.im : in_req[g].opnd.x.re;
      fp_req[g].opnd.b       = (st == ST_IM) ? in_req[g].opnd.y.im : in_req[g].opnd.y.re;
      fp_req[g].tag          = in_req[g].tag;
      fp_req[g].tag.part     = {1'b0, st == ST_IM};
      fp_req[g].tag.src      = 1'b0;
      in_ready[g]            = (st == ST_IM) && fp_ready[g];
      fp_rsp_ready[g]        = !out_valid[g] || out_ready[g];
    end

    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        st           <= ST_RE;
        out_valid[g] <= 1'b0;
        seen_re      <= 1'b0;
      end else begin
        if (fp_valid[g] && fp_ready[g])
          st <= (st == ST_RE) ? ST_IM : ST_RE;
        if (out_valid[g] && out_ready[g])
          out_valid[g] <= 1'b0;
        if (fp_rsp_valid[g] && fp_rsp_ready[g]) begin
          seen_re <= !fp_rsp[g].tag.part[0];
          if (fp_rsp[g].tag.part[0])
            out_valid[g] <= 1'b1;
        end
      end
    end

    always_ff @(posedge i_clk) begin
      if (fp_rsp_valid[g] && fp_rsp_ready[g]) begin
        if (fp_rsp[g].tag.part[0]) begin
          out_rsp[g].res.im <= fp_rsp[g].res;
          out_rsp[g].tag    <= fp_rsp[g].tag;
        end else begin
          out_rsp[g].res.re <= fp_rsp[g].res;
        end
      end
    end

    a_re_before_im: assert property (@(posedge i_clk) disable iff (i_rst)
      fp_rsp_valid[g] && fp_rsp_ready[g] && fp_rsp[g].tag.part[0] |-> seen_re);
  end

  // Multiply path, four products a*c, b*d, a*d, b*c
  typedef enum logic [1:0] {M_AC, M_BD, M_AD, M_BC} mul_state_e;
  mul_state_e       mst;
  fp_pkg::fe_pair_t sub_pair, add_pair;
  stream_pkg::tag_t sub_tag, add_tag;
  logic             sub_pv, add_pv;
  logic [1:0]       done;
  logic             mul_out;
  logic             sub_free, add_free;

  always_comb begin
    o_mul_fp_valid = i_mul_valid;
    o_mul_fp_req.opnd.a = mst[0] ? i_mul_req.opnd.x.im : i_mul_req.opnd.x.re;
    o_mul_fp_req.opnd.b = (mst == M_AC || mst == M_BC) ? i_mul_req.opnd.y.re
                                                      : i_mul_req.opnd.y.im;
    o_mul_fp_req.tag      = i_mul_req.tag;
    o_mul_fp_req.tag.part = mst;
    o_mul_fp_req.tag.src  = 1'b0;
    o_mul_ready = (mst == M_BC) && i_mul_fp_ready;
  end

  assign sub_free = !sub_pv || i_sub_fp_ready[1];
  assign add_free = !add_pv || i_add_fp_ready[1];
  assign o_mul_fp_rsp_ready = i_mul_fp_rsp.tag.part[1] ? add_free : sub_free;
  assign o_sub_fp_valid[1] = sub_pv;
  assign o_sub_fp_req[1]   = '{opnd: sub_pair, tag: sub_tag};
  assign o_add_fp_valid[1] = add_pv;
  assign o_add_fp_req[1]   = '{opnd: add_pair, tag: add_tag};

  assign o_mul_rsp_valid = &done;
  assign mul_out = o_mul_rsp_valid && i_mul_rsp_ready;
  assign o_sub_fp_rsp_ready[1] = !done[0] || mul_out;
  assign o_add_fp_rsp_ready[1] = !done[1] || mul_out;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mst    <= M_AC;
      sub_pv <= 1'b0;
      add_pv <= 1'b0;
      done   <= 2'b00;
    end else begin
      if (o_mul_fp_valid && i_mul_fp_ready)
        mst <= mul_state_e'(mst + 2'd1);
      if (sub_pv && i_sub_fp_ready[1])
        sub_pv <= 1'b0;
      if (add_pv && i_add_fp_ready[1])
        add_pv <= 1'b0;
      if (i_mul_fp_rsp_valid && o_mul_fp_rsp_ready) begin
        if (i_mul_fp_rsp.tag.part == 2'd1)
          sub_pv <= 1'b1;
        if (i_mul_fp_rsp.tag.part == 2'd3)
          add_pv <= 1'b1;
      end
      if (mul_out)
        done <= 2'b00;
      if (i_sub_fp_rsp_valid[1] && o_sub_fp_rsp_ready[1])
        done[0] <= 1'b1;
      if (i_add_fp_rsp_valid[1] && o_add_fp_rsp_ready[1])
        done[1] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_mul_fp_rsp_valid && o_mul_fp_rsp_ready) begin
      case (i_mul_fp_rsp.tag.part)
        2'd0: sub_pair.a <= i_mul_fp_rsp.res;
        2'd1: sub_pair.b <= i_mul_fp_rsp.res;
        2'd2: add_pair.a <= i_mul_fp_rsp.res;
        default: add_pair.b <= i_mul_fp_rsp.res;
      endcase
      if (i_mul_fp_rsp.tag.part[1])
        add_tag <= i_mul_fp_rsp.tag;
      else
        sub_tag <= i_mul_fp_rsp.tag;
    end
    if (i_sub_fp_rsp_valid[1] && o_sub_fp_rsp_ready[1]) begin
      o_mul_rsp.res.re <= i_sub_fp_rsp[1].res;
      o_mul_rsp.tag    <= i_sub_fp_rsp[1].tag;
    end
    if (i_add_fp_rsp_valid[1] && o_add_fp_rsp_ready[1])
      o_mul_rsp.res.im <= i_add_fp_rsp[1].res;
  end

endmodule

`default_nettype wire

// ==== source/fe2_alu_top.sv ====
`default_nettype none

module fe2_alu_top (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_add_valid,
  output logic                 o_add_ready,
  input  stream_pkg::fe2_req_t i_add_req,
  output logic                 o_add_rsp_valid,
  input  logic                 i_add_rsp_ready,
  output stream_pkg::fe2_rsp_t o_add_rsp,
  input  logic                 i_sub_valid,
  output logic                 o_sub_ready,
  input  stream_pkg::fe2_req_t i_sub_req,
  output logic                 o_sub_rsp_valid,
  input  logic                 i_sub_rsp_ready,
  output stream_pkg::fe2_rsp_t o_sub_rsp,
  input  logic                 i_mul_valid,
  output logic                 o_mul_ready,
  input  stream_pkg::fe2_req_t i_mul_req,
  output logic                 o_mul_rsp_valid,
  input  logic                 i_mul_rsp_ready,
  output stream_pkg::fe2_rsp_t o_mul_rsp
);

  // Arbiter side links
  logic                a_valid [2], a_ready [2], a_rsp_valid [2], a_rsp_ready [2];
  stream_pkg::fp_req_t a_req [2];
  stream_pkg::fp_rsp_t a_rsp [2];
  logic                s_valid [2], s_ready [2], s_rsp_valid [2], s_rsp_ready [2];
  stream_pkg::fp_req_t s_req [2];
  stream_pkg::fp_rsp_t s_rsp [2];

  // Unit side links
  logic                au_valid, au_ready, au_rsp_valid, au_rsp_ready;
  stream_pkg::fp_req_t au_req;
  stream_pkg::fp_rsp_t au_rsp;
  logic                su_valid, su_ready, su_rsp_valid, su_rsp_ready;
  stream_pkg::fp_req_t su_req;
  stream_pkg::fp_rsp_t su_rsp;
  logic                m_valid, m_ready, m_rsp_valid, m_rsp_ready;
  stream_pkg::fp_req_t m_req;
  stream_pkg::fp_rsp_t m_rsp;

  fe2_arithmetic u_arith (
    .i_clk, .i_rst,
    .i_add_valid, .o_add_ready, .i_add_req, .o_add_rsp_valid, .i_add_rsp_ready, .o_add_rsp,
    .i_sub_valid, .o_sub_ready, .i_sub_req, .o_sub_rsp_valid, .i_sub_rsp_ready, .o_sub_rsp,
    .i_mul_valid, .o_mul_ready, .i_mul_req, .o_mul_rsp_valid, .i_mul_rsp_ready, .o_mul_rsp,
    .o_add_fp_valid(a_valid), .i_add_fp_ready(a_ready), .o_add_fp_req(a_req),
    .i_add_fp_rsp_valid(a_rsp_valid), .o_add_fp_rsp_ready(a_rsp_ready), .i_add_fp_rsp(a_rsp),
    .o_sub_fp_valid(s_valid), .i_sub_fp_ready(s_ready), .o_sub_fp_req(s_req),
    .i_sub_fp_rsp_valid(s_rsp_valid), .o_sub_fp_rsp_ready(s_rsp_ready), .i_sub_fp_rsp(s_rsp),
    .o_mul_fp_valid(m_valid), .i_mul_fp_ready(m_ready), .o_mul_fp_req(m_req),
    .i_mul_fp_rsp_valid(m_rsp_valid), .o_mul_fp_rsp_ready(m_rsp_ready), .i_mul_fp_rsp(m_rsp)
  );

  fp_resource_share share_add (
    .i_clk, .i_rst,
    .i_req_valid(a_valid), .o_req_ready(a_ready), .i_req(a_req),
    .o_unit_valid(au_valid), .i_unit_ready(au_ready), .o_unit_req(au_req),
    .i_unit_rsp_valid(au_rsp_valid), .o_unit_rsp_ready(au_rsp_ready), .i_unit_rsp(au_rsp),
    .o_rsp_valid(a_rsp_valid), .i_rsp_ready(a_rsp_ready), .o_rsp(a_rsp)
  );

  fp_resource_share share_sub (
    .i_clk, .i_rst,
    .i_req_valid(s_valid), .o_req_ready(s_ready), .i_req(s_req),
    .o_unit_valid(su_valid), .i_unit_ready(su_ready), .o_unit_req(su_req),
    .i_unit_rsp_valid(su_rsp_valid), .o_unit_rsp_ready(su_rsp_ready), .i_unit_rsp(su_rsp),
    .o_rsp_valid(s_rsp_valid), .i_rsp_ready(s_rsp_ready), .o_rsp(s_rsp)
  );

  fp_mod_addsub #(.OP(stream_pkg::FP_ADD)) u_fp_add (
    .i_clk, .i_rst,
    .i_req_valid(au_valid), .o_req_ready(au_ready), .i_req(au_req),
    .o_rsp_valid(au_rsp_valid), .i_rsp_ready(au_rsp_ready), .o_rsp(au_rsp)
  );

  fp_mod_addsub #(.OP(stream_pkg::FP_SUB)) u_fp_sub (
    .i_clk, .i_rst,
    .i_req_valid(su_valid), .o_req_ready(su_ready), .i_req(su_req),
    .o_rsp_valid(su_rsp_valid), .i_rsp_ready(su_rsp_ready), .o_rsp(su_rsp)
  );

  fp_mod_mul u_fp_mul (
    .i_clk, .i_rst,
    .i_req_valid(m_valid), .o_req_ready(m_ready), .i_req(m_req),
    .o_rsp_valid(m_rsp_valid), .i_rsp_ready(m_rsp_ready), .o_rsp(m_rsp)
  );

endmodule

`default_nettype wire

// ==== test/fe2_alu_tb.sv ====
`default_nettype none

module fe2_alu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD = 4;
  localparam int OP_ADD = 0;
  localparam int OP_SUB = 1;
  localparam int OP_MUL = 2;
  localparam int N_DIRECTED = 8;
  localparam int N_OPS = 40;
  localparam int WATCHDOG_NS = (200 * 3 * N_OPS + 1000) * PERIOD;
  localparam longint unsigned PRIME = 65521;

  // Corner operands as {re, im}, shared by all three streams
  localparam logic [31:0] DIR_X [8] = '{32'h0000_0000, 32'h0001_0000, 32'h0000_0001,
    32'hFFF0_FFF0, 32'h0005_0003, 32'h0000_0000, 32'hFFF0_0001, 32'h3039_D431};
  localparam logic [31:0] DIR_Y [8] = '{32'h0000_0000, 32'hFFF0_FFF0, 32'h0000_0001,
    32'hFFF0_FFF0, 32'hFFEF_0007, 32'h0001_FFF0, 32'h0000_0001, 32'hFFF0_8000};

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic req_valid [3] = '{default: 1'b0};
  logic req_ready [3];
  stream_pkg::fe2_req_t req [3] = '{default: '0};
  logic rsp_valid [3];
  logic rsp_ready [3] = '{default: 1'b1};
  stream_pkg::fe2_rsp_t rsp [3];

  integer       seed = 8;
  int           errors = 0;
  int           sent [3] = '{default: 0};
  int           rcvd [3] = '{default: 0};
  logic [7:0]   next_id [3] = '{8'h10, 8'h40, 8'h80};
  string        names [3] = '{"add", "sub", "mul"};
  fp_pkg::fe2_t exp_q [3][$];
  logic [7:0]   id_q [3][$];

  fe2_alu_top fe2_alu_top_inst (
    .i_clk(clk), .i_rst(rst),
    .i_add_valid(req_valid[0]), .o_add_ready(req_ready[0]), .i_add_req(req[0]),
    .o_add_rsp_valid(rsp_valid[0]), .i_add_rsp_ready(rsp_ready[0]), .o_add_rsp(rsp[0]),
    .i_sub_valid(req_valid[1]), .o_sub_ready(req_ready[1]), .i_sub_req(req[1]),
    .o_sub_rsp_valid(rsp_valid[1]), .i_sub_rsp_ready(rsp_ready[1]), .o_sub_rsp(rsp[1]),
    .i_mul_valid(req_valid[2]), .o_mul_ready(req_ready[2]), .i_mul_req(req[2]),
    .o_mul_rsp_valid(rsp_valid[2]), .i_mul_rsp_ready(rsp_ready[2]), .o_mul_rsp(rsp[2])
  );

  always #(PERIOD / 2) clk = ~clk;

  // Expected Fp2 result straight from the field formulas
  function automatic fp_pkg::fe2_t ref_result(input int op, input fp_pkg::fe2_t x,
                                              input fp_pkg::fe2_t y);
    longint unsigned a, b, c, d;
    fp_pkg::fe2_t r;
    a = x.re;
    b = x.im;
    c = y.re;
    d = y.im;
    case (op)
      OP_ADD: begin
        r.re = fp_pkg::fe_t'((a + c) % PRIME);
        r.im = fp_pkg::fe_t'((b + d) % PRIME);
      end
      OP_SUB: begin
        r.re = fp_pkg::fe_t'((a + PRIME - c) % PRIME);
        r.im = fp_pkg::fe_t'((b + PRIME - d) % PRIME);
      end
      default: begin
        // (ac - bd) + (ad + bc) i
        r.re = fp_pkg::fe_t'(((a * c) % PRIME + PRIME - (b * d) % PRIME) % PRIME);
        r.im = fp_pkg::fe_t'((a * d + b * c) % PRIME);
      end
    endcase
    return r;
  endfunction

  function automatic fp_pkg::fe2_t rand_fe2();
    fp_pkg::fe2_t e;
    e.re = fp_pkg::fe_t'($unsigned($random(seed)) % PRIME);
    e.im = fp_pkg::fe_t'($unsigned($random(seed)) % PRIME);
    return e;
  endfunction

  function automatic bit responses_done();
    for (int k = 0; k < 3; k++)
      if (rcvd[k] != sent[k]) return 1'b0;
    return 1'b1;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_idle();
    for (int k = 0; k < 3; k++)
      check($sformatf("o_%s_rsp_valid", names[k]), 32'(rsp_valid[k]), 32'd0);
  endtask

  task automatic report_counts();
    $display("Errors %0d, responses add %0d/%0d sub %0d/%0d mul %0d/%0d", errors,
             rcvd[0], sent[0], rcvd[1], sent[1], rcvd[2], sent[2]);
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send(input int op, input fp_pkg::fe2_t x, input fp_pkg::fe2_t y);
    req[op].opnd.x = x;
    req[op].opnd.y = y;
    req[op].tag = '{id: next_id[op], part: 2'd0, src: 1'b0};
    req_valid[op] = 1'b1;
    do @(posedge clk); while (!req_ready[op]);
    exp_q[op].push_back(ref_result(op, x, y));
    id_q[op].push_back(next_id[op]);
    next_id[op]++;
    sent[op]++;
    @(negedge clk);
  endtask

  task automatic run_stream(input int op);
    fp_pkg::fe2_t x;
    fp_pkg::fe2_t y;
    for (int n = 0; n < N_OPS; n++) begin
      if (n < N_DIRECTED) begin
        x = DIR_X[n];
        y = DIR_Y[n];
      end else begin
        x = rand_fe2();
        y = rand_fe2();
      end
      send(op, x, y);
    end
    req_valid[op] = 1'b0;
  endtask

  // Random back-pressure on all response streams
  always @(negedge clk) begin
    for (int k = 0; k < 3; k++)
      rsp_ready[k] = (($random(seed) & 3) != 0);
  end

  // Scoreboard against the per-stream expectation queues
  always @(posedge clk) begin
    for (int k = 0; k < 3; k++) begin
      if (!rst && rsp_valid[k] && rsp_ready[k]) begin
        rcvd[k]++;
        if (exp_q[k].size() == 0) begin
          $display("A %s response arrived with no request outstanding", names[k]);
          errors++;
        end else begin
          check($sformatf("o_%s_rsp.res", names[k]), rsp[k].res, exp_q[k].pop_front());
          check($sformatf("o_%s_rsp.tag.id", names[k]), 32'(rsp[k].tag.id),
                32'(id_q[k].pop_front()));
        end
      end
    end
  end

  initial begin
    repeat (3) begin
      @(negedge clk);
      check_idle();
    end
    rst = 1'b0;
    @(negedge clk);
    check_idle();
    // All three streams at once so the shared units see contention
    fork
      run_stream(OP_ADD);
      run_stream(OP_SUB);
      run_stream(OP_MUL);
    join
    while (!responses_done()) @(negedge clk);
    // Extra cycles so a duplicated response would still be seen
    repeat (20) @(negedge clk);
    for (int k = 0; k < 3; k++)
      check($sformatf("%s response count", names[k]), rcvd[k], sent[k]);
    report_counts();
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the DUT stopped returning responses", WATCHDOG_NS);
    report_counts();
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fe2_alu_top.f ====
source/fp_pkg.sv
source/stream_pkg.sv
source/fp_mod_addsub.sv
source/fp_mod_mul.sv
source/fp_resource_share.sv
source/fe2_arithmetic.sv
source/fe2_alu_top.sv
test/fe2_alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the fe2_alu_top testbench with Verilator, runs it and scans the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal -f fe2_alu_top.f \
  --top-module fe2_alu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vfe2_alu_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0
